//--- verilog.f
+incdir+hdl
hdl/flux_drive_pkg.sv
hdl/drive_status_if.sv
hdl/sony_cmd_decoder.sv
hdl/spindle_ctrl.sv
hdl/head_stepper.sv
hdl/disk_rotation.sv
hdl/status_sense.sv
hdl/flux_drive_top.sv
verif/tb_flux_drive.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_flux_drive
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTS PASSED

SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_flux_drive.sv
// Self-checking testbench for the drive top; models track memory, checks status, steps and flux
`timescale 1ns/1ps
`default_nettype none

module tb_flux_drive
    import flux_drive_pkg::*;
();

    // ========================================
    // Reference geometry
    // ========================================
    localparam int CELL      = 28;      // Cycles per bit cell
    localparam int BITS      = 512;     // Bits in the test track
    localparam int SPIN_ROTS = 2;       // Turns before ready
    localparam int TOP_TRACK = 79;
    localparam int READY_DELAY = SPIN_ROTS * BITS * CELL + 1;

    logic       CLK_14M;
    logic       RESET;
    logic [3:0] phases;
    logic [2:0] sense_reg;
    logic       diskreg_sel;
    logic       sw_motor_on;
    logic       disk_mounted;
    logic       disk_wp;
    logic       track_loaded;
    bit_pos_t   track_bit_count;
    logic [7:0] bram_data;
    logic       flux_transition;
    logic       sense;
    logic       motor_spinning;
    logic       drive_ready;
    track_t     track;
    bit_pos_t   bit_position;
    byte_addr_t bram_addr;

    logic [7:0] track_mem [0:63];   // 64-byte track buffer model

    // Model of the drive as the testbench expects it
    logic m_dir;
    logic m_motor_cmd;
    logic m_ready;
    int   m_track;

    int   error_count;      // Main sequence errors
    int   flux_errors;      // Errors from the flux compare process
    int   errors_at_start;
    int   test_count;
    int   failed_tests;
    logic timed_out;        // Set when a wait gave up

    // Flux compare process state
    int   spin_cycles = 0;
    logic was_spinning = 1'b0;
    logic loaded_q = 1'b0;
    logic exp_flux;

    flux_drive_top u_flux_drive_top (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .phases          (phases),
        .sense_reg       (sense_reg),
        .diskreg_sel     (diskreg_sel),
        .sw_motor_on     (sw_motor_on),
        .disk_mounted    (disk_mounted),
        .disk_wp         (disk_wp),
        .track_loaded    (track_loaded),
        .track_bit_count (track_bit_count),
        .bram_data       (bram_data),
        .flux_transition (flux_transition),
        .sense           (sense),
        .motor_spinning  (motor_spinning),
        .drive_ready     (drive_ready),
        .track           (track),
        .bit_position    (bit_position),
        .bram_addr       (bram_addr)
    );

    assign bram_data = track_mem[bram_addr[5:0]];   // Same-cycle read

    initial begin
        CLK_14M = 1'b0;
        forever #5 CLK_14M = ~CLK_14M;              // 10 ns period
    end

    // ========================================
    // Reference functions
    // ========================================
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Track bit at a position with the MSB of each byte first
    function automatic logic ref_bit(input int pos);
        logic [7:0] byte_val;
        byte_val = track_mem[6'(pos / 8)];
        return byte_val[3'(7 - (pos % 8))];
    endfunction

    // Flux level n cycles after the spindle rise
    function automatic logic flux_expected(input int n);
        int m;
        if (n < 2)
            return 1'b0;
        if (((n - 2) % CELL) != 0)
            return 1'b0;
        m = (n - 2) / CELL;                     // Cell index since the rewind
        if (m < SPIN_ROTS * BITS)
            return 1'b0;                        // Still spinning up
        return ref_bit(m % BITS);
    endfunction

    // Sense line by the status table
    function automatic logic expected_sense(input logic [3:0] idx);
        case (idx)
            4'h0: return m_dir;
            4'h2: return !m_motor_cmd;
            4'h4, 4'h5, 4'h7, 4'hC, 4'hD: return 1'b0;
            4'h8: return !disk_mounted;
            4'h9: return !disk_wp;
            4'hA: return (m_track != 0);
            4'hE: return !m_ready;
            default: return 1'b1;               // 1, 3, 6, B, F
        endcase
    endfunction

    // ========================================
    // Flux compare process
    // ========================================
    always @(posedge CLK_14M) loaded_q <= track_loaded;

    always @(negedge CLK_14M) begin
        // Flux can still go out one cycle after the stop
        if (motor_spinning || was_spinning) begin
            exp_flux = flux_expected(spin_cycles) && loaded_q;
            if (flux_transition !== exp_flux) begin
                $display("MISMATCH flux_compare: expected %0b actual %0b at cycle %0d",
                         exp_flux, flux_transition, spin_cycles);
                flux_errors = flux_errors + 1;
            end
            spin_cycles = spin_cycles + 1;
        end else begin
            spin_cycles = 0;
            if (flux_transition !== 1'b0) begin
                $display("MISMATCH flux_compare: expected 0 actual %0b with motor off",
                         flux_transition);
                flux_errors = flux_errors + 1;
            end
        end
        was_spinning = motor_spinning;
    end

    // ========================================
    // Check and sequencing tasks
    // ========================================
    task automatic check_int(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("MISMATCH %s: expected %0d actual %0d", name, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    task note_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        error_count = error_count + 1;
        timed_out   = 1'b1;
    endtask

    task finish_test(input string name);
        test_count = test_count + 1;
        if (error_count + flux_errors == errors_at_start) begin
            $display("test %s: pass", name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %s: fail, %0d errors", name,
                     error_count + flux_errors - errors_at_start);
        end
        errors_at_start = error_count + flux_errors;
    endtask

    // Strobe one command and update the model by the command rules
    task apply_strobe(input logic [3:0] code);
        @(negedge CLK_14M);
        sense_reg   = code[2:0];
        diskreg_sel = code[3];
        phases[3]   = 1'b1;
        case (code)
            4'd0: m_dir = 1'b0;
            4'd4: m_dir = 1'b1;
            4'd2: begin
                if (disk_mounted)
                    m_motor_cmd = 1'b1;
            end
            4'd6: begin
                m_motor_cmd = 1'b0;
                m_ready     = 1'b0;
            end
            default: ;                          // Side 1 codes do nothing
        endcase
        @(negedge CLK_14M);
        phases[3] = 1'b0;
    endtask

    task send_cmd(input logic [3:0] code);
        apply_strobe(code);
        @(negedge CLK_14M);                     // Spindle has followed by now
    endtask

    task check_sense(input logic [3:0] idx, input string name);
        @(negedge CLK_14M);
        sense_reg   = idx[2:0];
        diskreg_sel = idx[3];
        @(negedge CLK_14M);
        check_int($sformatf("%s sense %0h", name, idx), int'(expected_sense(idx)), int'(sense));
    endtask

    task check_motor(input string name);
        check_int({name, " motor_spinning"}, int'(m_motor_cmd), int'(motor_spinning));
    endtask

    // One step pulse on CA1 with the direction on CA0
    task step_head(input logic up);
        @(negedge CLK_14M);
        phases[0] = up;
        phases[1] = 1'b1;
        @(negedge CLK_14M);
        phases[1] = 1'b0;                       // Falling edge moves the head
        @(negedge CLK_14M);
        if (m_motor_cmd || sw_motor_on) begin
            if (up && m_track < TOP_TRACK)
                m_track = m_track + 1;
            else if (!up && m_track > 0)
                m_track = m_track - 1;
        end
    endtask

    // Start the motor and count cycles from spindle rise to ready
    task spin_up_and_measure(input string name);
        int guard;
        int cycles;
        int early_flux;
        apply_strobe(4'd2);
        guard = 0;
        while (motor_spinning !== 1'b1 && guard < 20) begin
            guard = guard + 1;
            @(negedge CLK_14M);
        end
        if (motor_spinning !== 1'b1) begin
            note_timeout({name, " motor_spinning to rise"});
        end else begin
            check_int({name, " ready at start"}, 0, int'(drive_ready));
            cycles     = 0;
            early_flux = 0;
            while (drive_ready !== 1'b1 && cycles < 2 * READY_DELAY) begin
                @(negedge CLK_14M);
                cycles = cycles + 1;
                if (cycles == 1)
                    check_int({name, " bit_position"}, 0, int'(bit_position));   // Rewound
                if (flux_transition === 1'b1)
                    early_flux = early_flux + 1;
            end
            if (drive_ready !== 1'b1) begin
                note_timeout({name, " drive_ready to rise"});
            end else begin
                check_int({name, " ready delay"}, READY_DELAY, cycles);
                check_int({name, " flux before ready"}, 0, early_flux);
                m_ready = 1'b1;
            end
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        logic [31:0] rng;
        int          ones;
        int          pulses;

        RESET           = 1'b1;
        phases          = 4'b0000;
        sense_reg       = 3'd0;
        diskreg_sel     = 1'b0;
        sw_motor_on     = 1'b0;
        disk_mounted    = 1'b1;
        disk_wp         = 1'b1;
        track_loaded    = 1'b0;
        track_bit_count = 17'd512;
        m_dir           = 1'b0;
        m_motor_cmd     = 1'b0;
        m_ready         = 1'b0;
        m_track         = 0;
        error_count     = 0;
        flux_errors     = 0;
        errors_at_start = 0;
        test_count      = 0;
        failed_tests    = 0;
        timed_out       = 1'b0;

        // Random track contents and the count of 1 bits for the pulse total
        rng  = 32'h9325;
        ones = 0;
        for (int i = 0; i < 64; i++) begin
            rng          = lcg_next(rng);
            track_mem[i] = rng[23:16];
            for (int b = 0; b < 8; b++)
                ones = ones + int'(rng[16 + b]);
        end

        repeat (4) @(negedge CLK_14M);
        RESET = 1'b0;

        // Status after reset
        check_int("reset track", 0, int'(track));
        check_int("reset flux", 0, int'(flux_transition));
        check_int("reset motor_spinning", 0, int'(motor_spinning));
        check_int("reset drive_ready", 0, int'(drive_ready));
        for (int i = 0; i < 16; i++)
            check_sense(4'(i), "reset");
        finish_test("reset_status");

        // Commands
        send_cmd(4'd4);
        check_sense(4'h0, "dir down");
        send_cmd(4'd0);
        check_sense(4'h0, "dir up");
        send_cmd(4'd2);
        check_motor("motor on");
        check_sense(4'h2, "motor on");
        send_cmd(4'd6);
        check_motor("motor off");
        @(negedge CLK_14M);
        disk_mounted = 1'b0;
        send_cmd(4'd2);                         // Ignored without a disk
        check_motor("no disk");
        check_sense(4'h2, "no disk");
        check_sense(4'h8, "no disk");
        @(negedge CLK_14M);
        disk_mounted = 1'b1;
        send_cmd(4'hC);                         // Side 1 blocks every code
        check_sense(4'h0, "side1 dir");
        send_cmd(4'hA);
        check_motor("side1 motor on");
        send_cmd(4'd2);
        send_cmd(4'hE);
        check_motor("side1 motor off");
        send_cmd(4'd6);
        check_motor("motor off again");
        finish_test("commands");

        // Stepping with no move while the motor is off
        repeat (3) step_head(1'b1);
        check_int("stepping idle track", 0, int'(track));
        send_cmd(4'd2);
        for (int i = 0; i < 85; i++) begin
            step_head(1'b1);
            check_int("stepping up track", m_track, int'(track));
        end
        check_int("stepping top", TOP_TRACK, int'(track));
        check_sense(4'hA, "top track");
        for (int i = 0; i < 85; i++) begin
            step_head(1'b0);
            check_int("stepping down track", m_track, int'(track));
            if (i == 40)
                check_sense(4'hA, "mid track");
        end
        check_int("stepping bottom", 0, int'(track));
        check_sense(4'hA, "track 0");
        send_cmd(4'd6);
        finish_test("stepping");

        // Spin-up with a track loaded
        @(negedge CLK_14M);
        track_loaded = 1'b1;
        spin_up_and_measure("spinup");
        finish_test("spinup");

        if (!timed_out) begin
            // One full rotation of flux after ready, cell k starts at cycle 28 * k
            pulses = 0;
            for (int i = 0; i < BITS * CELL; i++) begin
                @(negedge CLK_14M);
                if (flux_transition === 1'b1) begin
                    pulses = pulses + 1;
                    check_int("flux bit_position", i / CELL, int'(bit_position));
                    check_int("flux bram_addr", i / CELL / 8, int'(bram_addr));
                    check_int("flux bit", 1, int'(ref_bit(i / CELL)));
                end
            end
            check_int("flux pulse count", ones, pulses);
            check_sense(4'hE, "ready");
            finish_test("flux_stream");

            // Motor off and a restart
            send_cmd(4'd6);
            check_int("stop drive_ready", 0, int'(drive_ready));
            check_motor("stop");
            pulses = 0;
            repeat (200) begin
                @(negedge CLK_14M);
                if (flux_transition === 1'b1)
                    pulses = pulses + 1;
            end
            check_int("stop flux count", 0, pulses);
            check_sense(4'hE, "stopped");
            spin_up_and_measure("restart");
            finish_test("motor_restart");
        end

        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests,
                 error_count + flux_errors);
        if (error_count + flux_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/flux_drive_top.sv
// Top of the 3.5-inch drive model; connects the drive blocks and exposes plain ports to the IWM
`timescale 1ns/1ps
`default_nettype none

module flux_drive_top
    import flux_drive_pkg::*;
(
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic [3:0] phases,          // CA0..CA2 and LSTRB
    input  logic [2:0] sense_reg,       // Latched status register select
    input  logic       diskreg_sel,
    input  logic       sw_motor_on,
    input  logic       disk_mounted,
    input  logic       disk_wp,
    input  logic       track_loaded,
    input  bit_pos_t   track_bit_count,
    input  logic [7:0] bram_data,
    output logic       flux_transition,
    output logic       sense,
    output logic       motor_spinning,
    output logic       drive_ready,
    output track_t     track,
    output bit_pos_t   bit_position,
    output byte_addr_t bram_addr
);

    // ========================================
    // Internal drive state
    // ========================================
    drive_status_if status_bus ();

    logic rotation_done;    // Disk rotation to spindle

    assign motor_spinning = status_bus.motor_spinning;
    assign drive_ready    = status_bus.drive_ready;
    assign track          = status_bus.track;

    // ========================================
    // Drive blocks
    // ========================================
    sony_cmd_decoder u_sony_cmd_decoder (
        .CLK_14M      (CLK_14M),
        .RESET        (RESET),
        .phases       (phases),
        .sense_reg    (sense_reg),
        .diskreg_sel  (diskreg_sel),
        .disk_mounted (disk_mounted),
        .status       (status_bus.command)
    );

    spindle_ctrl u_spindle_ctrl (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .sw_motor_on   (sw_motor_on),
        .disk_mounted  (disk_mounted),
        .rotation_done (rotation_done),
        .status        (status_bus.spindle)
    );

    head_stepper u_head_stepper (
        .CLK_14M (CLK_14M),
        .RESET   (RESET),
        .phases  (phases),
        .status  (status_bus.stepper)
    );

    disk_rotation u_disk_rotation (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .track_loaded    (track_loaded),
        .track_bit_count (track_bit_count),
        .bram_data       (bram_data),
        .bram_addr       (bram_addr),
        .bit_position    (bit_position),
        .flux_transition (flux_transition),
        .rotation_done   (rotation_done),
        .status          (status_bus.rotation)
    );

    status_sense u_status_sense (
        .sense_reg    (sense_reg),
        .diskreg_sel  (diskreg_sel),
        .disk_mounted (disk_mounted),
        .disk_wp      (disk_wp),
        .status       (status_bus.sense),
        .sense        (sense)
    );

endmodule

`default_nettype wire

//--- hdl/status_sense.sv
// Sixteen-way drive status mux that drives the IWM sense line from {side select, CA2..CA0}
`timescale 1ns/1ps
`default_nettype none

module status_sense
    import flux_drive_pkg::*;
(
    input  logic [2:0] sense_reg,       // Latched CA2..CA0
    input  logic       diskreg_sel,     // Side select bit
    input  logic       disk_mounted,
    input  logic       disk_wp,         // 1 = write protected
    drive_status_if.sense status,
    output logic       sense
);

    sense_reg_t sense_index;
    logic       at_track0;

    assign sense_index = {diskreg_sel, sense_reg};
    assign at_track0   = (status.track == '0);

    // Most lines are active low on this drive
    always_comb begin
        case (sense_index)
            4'h0: sense = status.step_direction;    // Step direction
            4'h1: sense = 1'b1;                     // Step done, no delay
            4'h2: sense = !status.motor_cmd_on;     // Motor on, low true
            4'h3: sense = 1'b1;                     // No disk change
            4'h4: sense = 1'b0;
            4'h5: sense = 1'b0;                     // Not MFM capable
            4'h6: sense = 1'b1;                     // Double sided
            4'h7: sense = 1'b0;                     // Drive present
            4'h8: sense = !disk_mounted;            // Disk in place, low true
            4'h9: sense = !disk_wp;                 // Low when protected
            4'hA: sense = !at_track0;               // Track 0, low true
            4'hB: sense = 1'b1;                     // Tachometer held high
            4'hC: sense = 1'b0;
            4'hD: sense = 1'b0;                     // GCR mode
            4'hE: sense = !status.drive_ready;      // Ready, low true
            4'hF: sense = 1'b1;                     // 800K interface
            default: sense = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/disk_rotation.sv
// Disk rotation model: bit-cell timer, bit position, track buffer read and flux pulse output
`timescale 1ns/1ps
`default_nettype none
`include "flux_drive_consts.svh"

module disk_rotation
    import flux_drive_pkg::*;
(
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic       track_loaded,        // Track buffer holds valid data
    input  bit_pos_t   track_bit_count,     // Bits in the loaded track
    input  logic [7:0] bram_data,           // Same-cycle read of bram_addr
    output byte_addr_t bram_addr,
    output bit_pos_t   bit_position,
    output logic       flux_transition,     // One-cycle pulse per 1 bit
    output logic       rotation_done,       // One-cycle pulse at the index wrap
    drive_status_if.rotation status
);

    localparam logic [4:0] CELL_FULL = 5'(`FD_BIT_CELL_CYCLES);

    // ========================================
    // Control decode
    // ========================================
    logic       prev_motor;
    logic       motor_start;    // First cycle with the spindle on
    logic       advance;        // Disk is turning under the head
    logic       cell_start;
    logic       cell_end;
    logic       at_last_bit;
    logic       current_bit;
    logic [4:0] cell_timer;     // Counts down through one bit cell

    assign motor_start = status.motor_spinning && !prev_motor;
    // Start cycle only rewinds, counting begins on the next one
    assign advance     = status.motor_spinning && track_loaded && !motor_start;
    assign cell_start  = advance && (cell_timer == CELL_FULL);
    assign cell_end    = advance && (cell_timer == 5'd1);

    // Widened by one bit so the compare cannot wrap
    assign at_last_bit   = ({1'b0, bit_position} + 18'd1) >= {1'b0, track_bit_count};
    assign rotation_done = cell_end && at_last_bit && (track_bit_count != '0);

    // Track buffer access, MSB of each byte goes first
    assign bram_addr   = bit_position[16:3];
    assign current_bit = bram_data[3'd7 - bit_position[2:0]];

    // ========================================
    // Timer, position and flux
    // ========================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            prev_motor      <= 1'b0;
            bit_position    <= '0;
            cell_timer      <= CELL_FULL;
            flux_transition <= 1'b0;
        end else begin
            prev_motor <= status.motor_spinning;

            // Flux only once spun up, so the IWM sees no data during spin-up
            flux_transition <= cell_start && current_bit && status.drive_ready;

            if (motor_start) begin
                bit_position <= '0;     // Rotation restarts at the index
                cell_timer   <= CELL_FULL;
            end else if (advance) begin
                if (cell_end) begin
                    cell_timer <= CELL_FULL;
                    if (track_bit_count != '0) begin
                        if (at_last_bit)
                            bit_position <= '0;         // Index wrap
                        else
                            bit_position <= bit_position + bit_pos_t'(1);
                    end
                end else begin
                    cell_timer <= cell_timer - 5'd1;
                end
            end else begin
                cell_timer <= CELL_FULL;    // Stopped or no track, position holds
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/head_stepper.sv
// Full-track head stepper driven by CA0 direction and CA1 step pulses, clamped to the disk
`timescale 1ns/1ps
`default_nettype none
`include "flux_drive_consts.svh"

module head_stepper
    import flux_drive_pkg::*;
(
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic [3:0] phases,      // Bit 0 = direction, bit 1 = step
    drive_status_if.stepper status
);

    logic prev_step;                // CA1 at the last edge
    logic step_fall;

    assign step_fall = prev_step && !phases[1];     // Step fires on the falling edge

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            prev_step    <= 1'b0;
            status.track <= '0;     // Head parks at track 0
        end else begin
            prev_step <= phases[1];

            // Head only moves while the spindle turns
            if (step_fall && status.motor_spinning) begin
                if (phases[0]) begin
                    // Inward, saturate at the last track
                    if (status.track < track_t'(`FD_MAX_TRACK))
                        status.track <= status.track + track_t'(1);
                end else begin
                    // Outward, saturate at track 0
                    if (status.track != '0)
                        status.track <= status.track - track_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/spindle_ctrl.sv
// Spindle FSM that follows the motor request and counts spin-up rotations to drive ready
`timescale 1ns/1ps
`default_nettype none
`include "flux_drive_consts.svh"

module spindle_ctrl
    import flux_drive_pkg::*;
(
    input  logic CLK_14M,
    input  logic RESET,
    input  logic sw_motor_on,       // IWM motor soft switch
    input  logic disk_mounted,
    input  logic rotation_done,     // One pulse per full disk turn
    drive_status_if.spindle status
);

    // ========================================
    // Motor request and state
    // ========================================
    logic           motor_req;      // Soft switch or Sony motor command
    spindle_state_e state;
    spindle_state_e state_next;
    logic [1:0]     spin_count;     // Rotations left before ready

    assign motor_req = sw_motor_on || status.motor_cmd_on;

    assign status.drive_ready = (state == READY);   // Follows the state register

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            STOPPED: begin
                // Spindle rises at this edge with a disk in place
                if (motor_req && !status.motor_spinning && disk_mounted)
                    state_next = SPINUP;
            end
            SPINUP: begin
                if (rotation_done && (spin_count == 2'd1))
                    state_next = READY;     // Last spin-up turn done
            end
            READY:   state_next = READY;
            default: state_next = STOPPED;
        endcase

        // Spindle stops at this same edge, so ready drops along with it
        if (!motor_req)
            state_next = STOPPED;
    end

    // ========================================
    // Registers
    // ========================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            status.motor_spinning <= 1'b0;
            state                 <= STOPPED;
            spin_count            <= 2'd0;
        end else begin
            status.motor_spinning <= motor_req;    // One cycle behind the request
            state                 <= state_next;

            if ((state_next == SPINUP) && (state != SPINUP))
                spin_count <= 2'(`FD_SPINUP_ROTATIONS);     // Fresh spin-up
            else if ((state == SPINUP) && rotation_done)
                spin_count <= spin_count - 2'd1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/sony_cmd_decoder.sv
// Turns strobed Sony drive commands from the IWM phase lines into direction and motor latches
`timescale 1ns/1ps
`default_nettype none
`include "flux_drive_consts.svh"

module sony_cmd_decoder
    import flux_drive_pkg::*;
(
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic [3:0] phases,          // Bit 3 is the LSTRB command strobe
    input  logic [2:0] sense_reg,       // Latched CA2..CA0 register select
    input  logic       diskreg_sel,     // Side select from the disk register
    input  logic       disk_mounted,
    drive_status_if.command status
);

    // ========================================
    // Strobe edge and command index
    // ========================================
    logic       prev_strobe;    // Strobe level at the last clock edge
    logic       cmd_strobe;
    sense_reg_t cmd_index;

    assign cmd_strobe = phases[3] && !prev_strobe;  // Rising edge of LSTRB
    // Side select sits above the register bits, so side 1 maps to codes 8..15
    assign cmd_index  = {diskreg_sel, sense_reg};

    // ========================================
    // Command latches
    // ========================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            prev_strobe           <= 1'b0;
            status.step_direction <= 1'b0;  // Default toward higher tracks
            status.motor_cmd_on   <= 1'b0;
        end else begin
            prev_strobe <= phases[3];

            if (cmd_strobe) begin
                case (cmd_index)
                    `FD_CMD_DIR_UP:    status.step_direction <= 1'b0;
                    `FD_CMD_DIR_DOWN:  status.step_direction <= 1'b1;
                    `FD_CMD_MOTOR_ON: begin
                        // Motor only starts with a disk in place
                        if (disk_mounted)
                            status.motor_cmd_on <= 1'b1;
                    end
                    `FD_CMD_MOTOR_OFF: status.motor_cmd_on <= 1'b0;
                    default: ;                      // Other codes are no-ops here
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/drive_status_if.sv
// Drive state bundle shared by the command, spindle, stepper, rotation and sense blocks
`timescale 1ns/1ps
`default_nettype none

interface drive_status_if
    import flux_drive_pkg::*;
();
    logic   step_direction;     // 1 = toward track 0, as the sense line reports it
    logic   motor_cmd_on;       // Motor state set by Sony commands
    logic   motor_spinning;     // Physical spindle rotation
    logic   drive_ready;        // Spun up after two turns
    track_t track;              // Current head track

    modport command  (output step_direction, output motor_cmd_on);
    modport spindle  (input motor_cmd_on, output motor_spinning, output drive_ready);
    modport stepper  (input motor_spinning, output track);
    modport rotation (input motor_spinning, input drive_ready);
    modport sense    (input step_direction, input motor_cmd_on, input motor_spinning,
                      input drive_ready, input track);
endinterface

`default_nettype wire

//--- hdl/flux_drive_pkg.sv
// Shared drive types; modules pull them in with a wildcard import in their headers
`default_nettype none
`include "flux_drive_consts.svh"

package flux_drive_pkg;

    // ========================================
    // Position types
    // ========================================

    // Head position, sized for the full track range
    typedef logic [$clog2(`FD_NUM_TRACKS)-1:0] track_t;

    typedef logic [16:0] bit_pos_t;     // Bit index around one track
    typedef logic [13:0] byte_addr_t;   // Byte address into track buffer

    // Status or command index: side select above the latched CA2..CA0
    typedef logic [3:0] sense_reg_t;

    // ========================================
    // Spindle motor states
    // ========================================
    typedef enum logic [1:0] {
        STOPPED,    // Motor off, or on without a disk rise
        SPINUP,     // Counting rotations after motor start
        READY       // At speed, flux goes out to the IWM
    } spindle_state_e;

endpackage

`default_nettype wire

//--- hdl/flux_drive_consts.svh
// Fixed geometry, bit cell timing and Sony command codes, included by drive RTL that needs them
`ifndef FLUX_DRIVE_CONSTS_SVH
`define FLUX_DRIVE_CONSTS_SVH

// ========================================
// Drive geometry
// ========================================
`define FD_NUM_TRACKS        80     // Full tracks per side on a 3.5-inch disk
`define FD_MAX_TRACK         79     // Innermost track, head stops here

// ========================================
// Rotation timing
// ========================================
`define FD_BIT_CELL_CYCLES   28     // 2 us bit cell at 14 MHz
`define FD_SPINUP_ROTATIONS  2      // Full turns before data is trusted

// ========================================
// Sony command codes, {side select, CA2..CA0}
// ========================================
`define FD_CMD_DIR_UP        4'd0   // Next step goes toward track 79
`define FD_CMD_MOTOR_ON      4'd2
`define FD_CMD_DIR_DOWN      4'd4   // Next step goes toward track 0
`define FD_CMD_MOTOR_OFF     4'd6

`endif
